//--- flist.f
design/tile_pkg.sv
design/tile_ram.sv
design/video_timing.sv
design/tile_map.sv
design/tile_video_top.sv
testbench/tile_asserts.sv
testbench/tile_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tile_tb -Mdir obj_dir -o tile_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tile_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

//--- testbench/tile_tb.sv
module tile_tb;

    import tile_pkg::*;

    // 256 by 256 pixels at two clk per pixel
    localparam int FRAME_CLKS = 131072;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cpu_cs;
    logic              cpu_wr_n;
    logic              cpu_asel;
    logic [SCAN_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_din;
    logic [DATA_W-1:0] cpu_dout;
    logic              busy;
    logic              flip;
    logic              pause;
    logic [DATA_W-1:0] msg_low;
    logic [DATA_W-1:0] msg_high;
    logic [H_W-1:0]    h;
    logic [V_W-1:0]    v;
    logic              hblank;
    logic              vblank;
    logic [DATA_W-1:0] tile_code;
    logic [DATA_W-1:0] tile_attr;

    // reference copy of both planes
    logic [DATA_W-1:0] model_code [0:1023];
    logic [DATA_W-1:0] model_attr [0:1023];

    // clk edges since reset release
    logic [31:0] cyc;
    logic [31:0] rng_state = 32'd90006;
    int          errors = 0;

    tile_video_top tile_video_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_cs    (cpu_cs),
        .cpu_wr_n  (cpu_wr_n),
        .cpu_asel  (cpu_asel),
        .cpu_addr  (cpu_addr),
        .cpu_din   (cpu_din),
        .cpu_dout  (cpu_dout),
        .busy      (busy),
        .flip      (flip),
        .pause     (pause),
        .msg_low   (msg_low),
        .msg_high  (msg_high),
        .h         (h),
        .v         (v),
        .hblank    (hblank),
        .vblank    (vblank),
        .tile_code (tile_code),
        .tile_attr (tile_attr)
    );

    always #10 clk = ~clk;

    // beam position follows from this count alone
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // drive and sample just after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t %s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic cpu_access(input logic wr, input logic sel, input logic [SCAN_W-1:0] a,
                              input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] rd);
        int         waits;
        logic [3:0] lead;
        cpu_cs = 1'b1;
        cpu_wr_n = !wr;
        cpu_asel = sel;
        cpu_addr = a;
        cpu_din = d;
        rd = '0;
        // pixel enable with h[2:0] at the slot follows a cyc value of 2*slot+1
        lead = {DATA_READ, 1'b1} - cyc[3:0];
        step();
        // scan side still owns the bus on the first clk
        check("busy", 32'd1, 32'(busy));
        waits = 1;
        while (busy === 1'b1 && waits <= 16) begin
            step();
            waits++;
        end
        if (busy !== 1'b0) begin
            $display("bus was never granted: busy high for over 16 clk at time %0t", $time);
            errors++;
        end else begin
            // busy high from the first clk up to the grant
            check("busy clk", 32'(lead) + 32'd1, 32'(waits - 1));
            // no back-pressure during the hold
            repeat (4) begin
                step();
                check("busy", 32'd0, 32'(busy));
            end
            rd = cpu_dout;
        end
        cpu_cs = 1'b0;
        cpu_wr_n = 1'b1;
        // cs low across one pixel enable hands the bus back
        step();
        step();
    endtask

    task automatic timing_check(input int n);
        logic [7:0] eh;
        logic [7:0] ev;
        repeat (n) begin
            eh = cyc[8:1];
            ev = cyc[16:9];
            check("pxl_cen", 32'(cyc[0]), 32'(tile_video_top_i.pxl_cen));
            check("h", 32'(eh), 32'(h));
            check("v", 32'(ev), 32'(v));
            check("hblank", 32'(eh >= H_VIS), 32'(hblank));
            check("vblank", 32'(ev >= V_VIS), 32'(vblank));
            step();
        end
    endtask

    task automatic scan_check(input int n, input logic inv, input logic paused);
        logic [7:0]        eh;
        logic [7:0]        ev;
        logic [SCAN_W-1:0] sa;
        repeat (n) begin
            step();
            eh = cyc[8:1];
            ev = cyc[16:9];
            // row over column
            sa = {ev[7:3], eh[7:3]};
            if (inv) begin
                sa = ~sa;
            end
            // tile settled from pixel 2 of each column on
            if (eh[2:0] >= 3'd2) begin
                if (paused) begin
                    check("tile_code", 32'(msg_low), 32'(tile_code));
                    check("tile_attr", 32'(msg_high), 32'(tile_attr));
                end else begin
                    check("tile_code", 32'(model_code[sa]), 32'(tile_code));
                    check("tile_attr", 32'(model_attr[sa]), 32'(tile_attr));
                end
            end
        end
    endtask

    task automatic reset_test();
        check("busy", 32'd0, 32'(busy));
        timing_check(1100);
        // skip ahead to the frame wrap
        while (cyc < 32'd130500) begin
            step();
        end
        timing_check(1200);
    endtask

    task automatic write_read_test();
        logic [SCAN_W-1:0] addrs [0:63];
        logic [31:0]       r;
        logic [DATA_W-1:0] rd;
        for (int i = 0; i < 64; i++) begin
            r = next_rand();
            addrs[i] = r[9:0];
            model_code[addrs[i]] = r[17:10];
            model_attr[addrs[i]] = r[25:18];
            cpu_access(1'b1, 1'b0, addrs[i], r[17:10], rd);
            cpu_access(1'b1, 1'b1, addrs[i], r[25:18], rd);
        end
        for (int i = 0; i < 64; i++) begin
            cpu_access(1'b0, 1'b0, addrs[i], '0, rd);
            check("cpu_dout code", 32'(model_code[addrs[i]]), 32'(rd));
            cpu_access(1'b0, 1'b1, addrs[i], '0, rd);
            check("cpu_dout attr", 32'(model_attr[addrs[i]]), 32'(rd));
        end
    endtask

    task automatic scan_test();
        logic [31:0]       r;
        logic [SCAN_W-1:0] wa;
        logic [DATA_W-1:0] rd;
        for (int a = 0; a < 1024; a++) begin
            r = next_rand();
            wa = 10'(a);
            model_code[wa] = r[7:0];
            model_attr[wa] = r[15:8];
            cpu_access(1'b1, 1'b0, wa, r[7:0], rd);
            cpu_access(1'b1, 1'b1, wa, r[15:8], rd);
        end
        flip = 1'b0;
        repeat (16) step();
        scan_check(FRAME_CLKS, 1'b0, 1'b0);
    endtask

    task automatic flip_test();
        flip = 1'b1;
        repeat (20) step();
        scan_check(FRAME_CLKS / 2, 1'b1, 1'b0);
        flip = 1'b0;
        repeat (20) step();
    endtask

    task automatic pause_test();
        msg_low = 8'h5a;
        msg_high = 8'hc3;
        pause = 1'b1;
        repeat (4) step();
        scan_check(512, 1'b0, 1'b1);
        pause = 1'b0;
        repeat (4) step();
        scan_check(512, 1'b0, 1'b0);
    endtask

    task automatic busy_test();
        logic [SCAN_W-1:0] a;
        logic [DATA_W-1:0] rd;
        for (int k = 0; k < 8; k++) begin
            // line cs up with pixel phase k
            while (cyc[3:1] != 3'(k)) begin
                step();
            end
            a = 10'(k * 97);
            cpu_access(1'b0, k[0], a, '0, rd);
            check("cpu_dout", 32'(k[0] ? model_attr[a] : model_code[a]), 32'(rd));
        end
    endtask

    // watchdog well past the length of all tests
    initial begin
        repeat (6 * FRAME_CLKS) @(posedge clk);
        $display("timeout: tests still running after six frames");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        cpu_cs = 1'b0;
        cpu_wr_n = 1'b1;
        cpu_asel = 1'b0;
        cpu_addr = '0;
        cpu_din = '0;
        flip = 1'b0;
        pause = 1'b0;
        msg_low = '0;
        msg_high = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_test();
        write_read_test();
        scan_test();
        flip_test();
        pause_test();
        busy_test();
        $display("summary: %0d check errors, %0d assertion failures",
                 errors, tile_video_top_i.u_map.u_asserts.fail_count);
        if (errors == 0 && tile_video_top_i.u_map.u_asserts.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tile_asserts.sv
module tile_asserts (
    input logic clk,
    input logic rst_n,
    input logic cs,
    input logic busy,
    input logic scan_sel,
    input logic we_code,
    input logic we_attr
);

    // failed assertions, read back at the end of the run
    int fail_count = 0;

    // one plane written at a time
    assert property (@(posedge clk) disable iff (!rst_n) !(we_code && we_attr))
        else begin
            $error("both plane write enables high together");
            fail_count++;
        end

    // scan side never writes
    assert property (@(posedge clk) disable iff (!rst_n) !(scan_sel && (we_code || we_attr)))
        else begin
            $error("write enable high while the scan side owns the bus");
            fail_count++;
        end

    // busy only answers a select seen one clk earlier
    assert property (@(posedge clk) disable iff (!rst_n) busy |-> $past(cs))
        else begin
            $error("busy high without cs in the previous clk");
            fail_count++;
        end

endmodule

bind tile_map tile_asserts u_asserts (.*);

//--- design/tile_video_top.sv
module tile_video_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // cpu bus
    input  logic                        cpu_cs,
    input  logic                        cpu_wr_n,
    input  logic                        cpu_asel,
    input  logic [tile_pkg::SCAN_W-1:0] cpu_addr,
    input  logic [tile_pkg::DATA_W-1:0] cpu_din,
    output logic [tile_pkg::DATA_W-1:0] cpu_dout,
    output logic                        busy,
    // screen control
    input  logic                        flip,
    input  logic                        pause,
    input  logic [tile_pkg::DATA_W-1:0] msg_low,
    input  logic [tile_pkg::DATA_W-1:0] msg_high,
    // beam position and blanking
    output logic [tile_pkg::H_W-1:0]    h,
    output logic [tile_pkg::V_W-1:0]    v,
    output logic                        hblank,
    output logic                        vblank,
    // tile under the beam
    output logic [tile_pkg::DATA_W-1:0] tile_code,
    output logic [tile_pkg::DATA_W-1:0] tile_attr
);

    // pixel enable shared by both blocks
    logic pxl_cen;

    // beam timing
    video_timing u_timing (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .h       (h),
        .v       (v),
        .hblank  (hblank),
        .vblank  (vblank)
    );

    // tile map rams and bus arbiter
    tile_map u_map (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .asel      (cpu_asel),
        .addr      (cpu_addr),
        .h         (h),
        .v         (v),
        .flip      (flip),
        .din       (cpu_din),
        .dout      (cpu_dout),
        .cs        (cpu_cs),
        .wr_n      (cpu_wr_n),
        .busy      (busy),
        .pause     (pause),
        .msg_low   (msg_low),
        .msg_high  (msg_high),
        .tile_code (tile_code),
        .tile_attr (tile_attr)
    );

endmodule

//--- design/tile_map.sv
module tile_map (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pxl_cen,
    // plane select, 0 is tile code and 1 is attribute
    input  logic                        asel,
    input  logic [tile_pkg::SCAN_W-1:0] addr,
    input  logic [tile_pkg::H_W-1:0]    h,
    input  logic [tile_pkg::V_W-1:0]    v,
    input  logic                        flip,
    input  logic [tile_pkg::DATA_W-1:0] din,
    output logic [tile_pkg::DATA_W-1:0] dout,
    input  logic                        cs,
    input  logic                        wr_n,
    output logic                        busy,
    input  logic                        pause,
    input  logic [tile_pkg::DATA_W-1:0] msg_low,
    input  logic [tile_pkg::DATA_W-1:0] msg_high,
    output logic [tile_pkg::DATA_W-1:0] tile_code,
    output logic [tile_pkg::DATA_W-1:0] tile_attr
);

    import tile_pkg::*;

    // address of the tile under the beam
    logic [SCAN_W-1:0] scan_addr;

    // bus owner, high while the scan side has the rams
    logic scan_sel;

    // scan_sel delayed to the address stage and to the ram output stage
    logic addr_scan;
    logic data_scan;

    // shared ram port
    logic [SCAN_W-1:0] ram_addr;
    logic [DATA_W-1:0] wr_data;
    logic              we_code;
    logic              we_attr;
    logic [DATA_W-1:0] q_code;
    logic [DATA_W-1:0] q_attr;

    // plane of the cpu access, kept for the read latch
    logic last_asel;

    // row over column, every bit flipped for a rotated screen
    assign scan_addr = {SCAN_W{flip}} ^ {v[7:3], h[7:3]};

    // hold the cpu while the scan side still owns the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= cs && scan_sel;
        end
    end

    // bus arbitration
    // cpu takes over at the data read slot
    // scan side comes back on the first pixel after cs drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_sel <= 1'b1;
        end else if (pxl_cen) begin
            if (!cs) begin
                scan_sel <= 1'b1;
            end else if (h[2:0] == DATA_READ) begin
                scan_sel <= 1'b0;
            end
        end
    end

    // write enables, one per plane
    // only the cpu side ever writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_code <= 1'b0;
            we_attr <= 1'b0;
        end else if (scan_sel) begin
            we_code <= 1'b0;
            we_attr <= 1'b0;
        end else begin
            we_code <= cs && !wr_n && !asel;
            we_attr <= cs && !wr_n && asel;
        end
    end

    // owner pipeline
    // follows the address into the rams and the data out of them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_scan <= 1'b1;
            data_scan <= 1'b1;
        end else begin
            addr_scan <= scan_sel;
            data_scan <= addr_scan;
        end
    end

    // address and write data mux
    always_ff @(posedge clk) begin
        if (scan_sel) begin
            ram_addr <= scan_addr;
        end else begin
            ram_addr  <= addr;
            wr_data   <= din;
            last_asel <= asel;
        end
    end

    // cpu read latch
    // q carries the cpu word here, valid from the third clk of the hold
    always_ff @(posedge clk) begin
        if (!data_scan) begin
            dout <= last_asel ? q_attr : q_code;
        end
    end

    // tile output latch
    // pause shows the message bytes instead of the map
    // left alone while the cpu has the rams
    always_ff @(posedge clk) begin
        if (data_scan) begin
            tile_code <= pause ? msg_low : q_code;
            tile_attr <= pause ? msg_high : q_attr;
        end
    end

    // tile code plane
    tile_ram #(
        .ADDR_W (SCAN_W)
    ) u_ram_code (
        .clk  (clk),
        .addr (ram_addr),
        .data (wr_data),
        .we   (we_code),
        .q    (q_code)
    );

    // tile attribute plane
    tile_ram #(
        .ADDR_W (SCAN_W)
    ) u_ram_attr (
        .clk  (clk),
        .addr (ram_addr),
        .data (wr_data),
        .we   (we_attr),
        .q    (q_attr)
    );

endmodule

//--- design/video_timing.sv
module video_timing (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     pxl_cen,
    output logic [tile_pkg::H_W-1:0] h,
    output logic [tile_pkg::V_W-1:0] v,
    output logic                     hblank,
    output logic                     vblank
);

    import tile_pkg::*;

    // next beam position
    logic [H_W-1:0] h_next;
    logic [V_W-1:0] v_next;

    // h always steps by one pixel
    assign h_next = h + 1'b1;

    // v steps only when h rolls over from 255 to 0
    assign v_next = (h == '1) ? v + 1'b1 : v;

    // pixel enable, one clk high out of two
    // starts low right after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // beam counters
    // both move on the pixel enable only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (pxl_cen) begin
            h <= h_next;
            v <= v_next;
        end
    end

    // blanking flags
    // computed from the next count so they line up with h and v
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // position 0,0 is visible
            hblank <= 1'b0;
            vblank <= 1'b0;
        end else if (pxl_cen) begin
            // horizontal blank from H_VIS up to the wrap
            hblank <= (h_next >= H_VIS);
            // vertical blank from V_VIS up to the wrap
            vblank <= (v_next >= V_VIS);
        end
    end

endmodule

//--- design/tile_ram.sv
module tile_ram #(
    parameter int ADDR_W = tile_pkg::SCAN_W
) (
    input  logic                        clk,
    input  logic [ADDR_W-1:0]           addr,
    input  logic [tile_pkg::DATA_W-1:0] data,
    input  logic                        we,
    output logic [tile_pkg::DATA_W-1:0] q
);

    import tile_pkg::*;

    // one word per tile
    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

    // single port, registered read
    // a write returns the old word on q
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

//--- design/tile_pkg.sv
package tile_pkg;

    // tile map geometry
    // 32 columns by 32 rows of 8x8 tiles
    localparam int SCAN_W = 10;

    // word width of both planes and of the cpu bus
    localparam int DATA_W = 8;

    // beam counter widths
    // both wrap at 256 on their own
    localparam int H_W = 8;
    localparam int V_W = 8;

    // pixel phase inside a tile column where the cpu gets the bus
    // matches the data read slot of the original boards
    localparam logic [2:0] DATA_READ = 3'd2;

    // first horizontal count inside blanking
    // blank until h wraps back to 0
    localparam logic [H_W-1:0] H_VIS = H_W'(224);

    // first vertical count inside blanking
    // blank until v wraps back to 0
    localparam logic [V_W-1:0] V_VIS = V_W'(240);

endpackage
